//--- tests/system_patterns.hex
// Columns: op address data sel expected err
// op 1 write, 2 read, 3 poll (data is mask), 4 wait o_irq, 5 read at most, 0 end
// Boot memory full words
1 00000000 12345678 f 00000000 0
1 00000004 deadbeef f 00000000 0
1 000003fc cafef00d f 00000000 0
2 00000000 00000000 f 12345678 0
2 00000004 00000000 f deadbeef 0
2 000003fc 00000000 f cafef00d 0
// Byte merges
1 00000000 aabbccdd 1 00000000 0
2 00000000 00000000 f 123456dd 0
1 00000000 aabbccdd 6 00000000 0
2 00000000 00000000 f 12bbccdd 0
1 00000004 00112233 8 00000000 0
2 00000004 00000000 f 00adbeef 0
1 000003fc 55aa55aa c 00000000 0
2 000003fc 00000000 f 55aaf00d 0
// Unmapped region, then boot memory again
2 20000000 00000000 f 00000000 1
1 20000000 ffffffff f 00000000 1
2 00000004 00000000 f 00adbeef 0
// Timer 0 expiry and clear
1 13000000 00000014 f 00000000 0
1 13000008 00000001 f 00000000 0
3 14000004 00000001 f 00000001 0
5 13000004 00000000 f 00000014 0
1 1300000c 00000000 f 00000000 0
2 14000004 00000000 f 00000000 0
1 13000008 00000000 f 00000000 0
1 1300000c 00000000 f 00000000 0
2 14000004 00000000 f 00000000 0
2 13000008 00000000 f 00000000 0
// Timer 1 flag with masking
1 13000100 00000014 f 00000000 0
1 13000108 00000001 f 00000000 0
3 14000004 00000002 f 00000002 0
2 14000000 00000000 f 00000000 0
4 00000000 00000000 f 00000000 0
1 14000008 00000002 f 00000000 0
4 00000000 00000000 f 00000001 0
2 14000000 00000000 f 00000002 0
1 1400000c 00000002 f 00000000 0
4 00000000 00000000 f 00000000 0
1 13000108 00000000 f 00000000 0
1 1300010c 00000000 f 00000000 0
2 14000004 00000000 f 00000000 0
// Software interrupt
1 14000010 00000001 f 00000000 0
2 14000004 00000000 f 00000008 0
4 00000000 00000000 f 00000000 0
1 14000008 00000008 f 00000000 0
4 00000000 00000000 f 00000001 0
2 14000000 00000000 f 00000008 0
1 14000014 00000001 f 00000000 0
4 00000000 00000000 f 00000000 0
2 14000004 00000000 f 00000000 0
0 00000000 00000000 0 00000000 0

//--- files.f
+incdir+verilog
verilog/system_pkg.sv
verilog/wb_bus_ctrl.sv
verilog/boot_mem.sv
verilog/timer_module.sv
verilog/interrupt_controller.sv
verilog/system.sv
tests/system_asserts.sv
tests/tb_system.sv

//--- tests/tb_system.sv
// --------------------------------------------------------------------------
// System testbench
// Replays bus operations from the pattern file through a Wishbone master
// task and checks responses, read data and the interrupt request
// --------------------------------------------------------------------------

`include "system_settings.svh"

module tb_system
    import system_pkg::*;
();

    localparam int FIELDS      = 6;
    localparam int MAX_ENTRIES = 64;
    localparam int BUS_TIMEOUT = 20;
    localparam int POLL_LIMIT  = 100;
    localparam int IRQ_TIMEOUT = 50;

    // Operation codes in the first column of the pattern file
    localparam logic [3:0] OP_END      = 4'h0;
    localparam logic [3:0] OP_WRITE    = 4'h1;
    localparam logic [3:0] OP_READ     = 4'h2;
    localparam logic [3:0] OP_POLL     = 4'h3;
    localparam logic [3:0] OP_IRQ      = 4'h4;
    localparam logic [3:0] OP_READ_MAX = 4'h5;

    logic     clk;
    logic     rst_n;
    wb_addr_t wb_adr;
    wb_sel_t  wb_sel;
    logic     wb_we;
    logic     wb_cyc;
    logic     wb_stb;
    wb_data_t wb_wdat;
    wb_data_t wb_rdat;
    logic     wb_ack;
    logic     wb_err;
    logic     irq;

    wb_data_t patterns [FIELDS*MAX_ENTRIES];

    int checks;
    int mismatches;
    int other_errors;

    system i_system (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_wb_adr (wb_adr),
        .i_wb_sel (wb_sel),
        .i_wb_we  (wb_we),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_dat (wb_wdat),
        .o_wb_dat (wb_rdat),
        .o_wb_ack (wb_ack),
        .o_wb_err (wb_err),
        .o_irq    (irq)
    );

    always #2 clk = ~clk;

    // ----------------------------------------------------------------------
    // Bus master
    // ----------------------------------------------------------------------
    // Called one time unit after a rising edge, returns at the same phase
    task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                              input wb_sel_t sel, output wb_data_t rdat, output logic ack,
                              output logic err, output logic responded);
        int cycles;
        wb_cyc    = 1'b1;
        wb_stb    = 1'b1;
        wb_we     = we;
        wb_adr    = adr;
        wb_sel    = sel;
        wb_wdat   = wdat;
        cycles    = 0;
        responded = 1'b0;
        rdat      = '0;
        ack       = 1'b0;
        err       = 1'b0;
        while (!responded && cycles < BUS_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (wb_ack || wb_err) begin
                responded = 1'b1;
                ack       = wb_ack;
                err       = wb_err;
                rdat      = wb_rdat;
            end
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        assert (responded) else begin
            $display("bus access to address %h got neither ack nor err within %0d cycles",
                     adr, BUS_TIMEOUT);
            other_errors++;
        end
        // Strobe stays low for one full cycle
        @(posedge clk);
        #1;
    endtask

    task automatic check_response(input wb_addr_t adr, input logic exp_err, input logic ack,
                                  input logic err);
        checks++;
        assert (err === exp_err) else begin
            $display("mismatch o_wb_err at %h: expected %h, got %h", adr, exp_err, err);
            mismatches++;
        end
        assert (ack === !exp_err) else begin
            $display("mismatch o_wb_ack at %h: expected %h, got %h", adr, !exp_err, ack);
            mismatches++;
        end
    endtask

    task automatic check_data(input wb_addr_t adr, input wb_data_t exp, input wb_data_t got);
        checks++;
        assert (got === exp) else begin
            $display("mismatch o_wb_dat at %h: expected %h, got %h", adr, exp, got);
            mismatches++;
        end
    endtask

    // Repeated reads until the masked value matches
    task automatic poll_until(input wb_addr_t adr, input wb_data_t mask, input wb_data_t exp,
                              input wb_sel_t sel);
        wb_data_t rdat;
        logic     ack;
        logic     err;
        logic     responded;
        logic     hit;
        int       polls;
        polls = 0;
        hit   = 1'b0;
        while (!hit && polls < POLL_LIMIT) begin
            bus_access(1'b0, adr, '0, sel, rdat, ack, err, responded);
            polls++;
            if (responded) begin
                check_response(adr, 1'b0, ack, err);
            end
            hit = ((rdat & mask) === exp);
        end
        assert (hit) else begin
            $display("bits %h at address %h never matched %h within %0d reads",
                     mask, adr, exp, POLL_LIMIT);
            other_errors++;
        end
    endtask

    task automatic wait_irq(input logic level);
        int cycles;
        cycles = 0;
        while (irq !== level && cycles < IRQ_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        checks++;
        assert (irq === level) else begin
            $display("o_irq did not reach %0d within %0d cycles", level, IRQ_TIMEOUT);
            other_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Pattern replay
    // ----------------------------------------------------------------------
    task automatic run_entry(input int idx);
        int         base;
        logic [3:0] op;
        wb_addr_t   adr;
        wb_data_t   dat;
        wb_sel_t    sel;
        wb_data_t   exp;
        logic       exp_err;
        wb_data_t   rdat;
        logic       ack;
        logic       err;
        logic       responded;
        base    = idx * FIELDS;
        op      = patterns[base][3:0];
        adr     = patterns[base+1];
        dat     = patterns[base+2];
        sel     = patterns[base+3][3:0];
        exp     = patterns[base+4];
        exp_err = patterns[base+5][0];
        case (op)
            OP_WRITE: begin
                bus_access(1'b1, adr, dat, sel, rdat, ack, err, responded);
                if (responded) begin
                    check_response(adr, exp_err, ack, err);
                end
            end
            OP_READ: begin
                bus_access(1'b0, adr, '0, sel, rdat, ack, err, responded);
                if (responded) begin
                    check_response(adr, exp_err, ack, err);
                    check_data(adr, exp, rdat);
                end
            end
            OP_READ_MAX: begin
                bus_access(1'b0, adr, '0, sel, rdat, ack, err, responded);
                if (responded) begin
                    check_response(adr, exp_err, ack, err);
                    checks++;
                    assert (rdat <= exp) else begin
                        $display("mismatch o_wb_dat at %h: expected at most %h, got %h",
                                 adr, exp, rdat);
                        mismatches++;
                    end
                end
            end
            OP_POLL: poll_until(adr, dat, exp, sel);
            OP_IRQ:  wait_irq(exp[0]);
            default: begin
                assert (1'b0) else begin
                    $display("pattern entry %0d has unknown operation %h", idx, op);
                    other_errors++;
                end
            end
        endcase
    endtask

    initial begin
        int       idx;
        wb_data_t rdat;
        logic     ack;
        logic     err;
        logic     responded;

        clk          = 1'b0;
        rst_n        = 1'b0;
        wb_adr       = '0;
        wb_sel       = '0;
        wb_we        = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_wdat      = '0;
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;

        for (int i = 0; i < FIELDS*MAX_ENTRIES; i++) begin
            patterns[i] = '0;
        end
        $readmemh("tests/system_patterns.hex", patterns);

        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Outputs right after reset
        checks++;
        assert (wb_ack === 1'b0) else begin
            $display("mismatch o_wb_ack after reset: expected 0, got %h", wb_ack);
            mismatches++;
        end
        assert (wb_err === 1'b0) else begin
            $display("mismatch o_wb_err after reset: expected 0, got %h", wb_err);
            mismatches++;
        end
        assert (irq === 1'b0) else begin
            $display("mismatch o_irq after reset: expected 0, got %h", irq);
            mismatches++;
        end

        bus_access(1'b0, {`BUS_REGION_IC, 16'h0000, `IC_RAW_STATUS}, '0, 4'hF,
                   rdat, ack, err, responded);
        if (responded) begin
            check_response({`BUS_REGION_IC, 16'h0000, `IC_RAW_STATUS}, 1'b0, ack, err);
            check_data({`BUS_REGION_IC, 16'h0000, `IC_RAW_STATUS}, '0, rdat);
        end

        idx = 0;
        while (idx < MAX_ENTRIES && patterns[idx*FIELDS][3:0] != OP_END) begin
            run_entry(idx);
            idx++;
        end
        assert (idx > 0) else begin
            $display("pattern file supplied no entries");
            other_errors++;
        end

        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- tests/system_asserts.sv
// --------------------------------------------------------------------------
// Bus controller assertions
// Handshake exclusivity, fixed response latency and one-hot slave strobes
// --------------------------------------------------------------------------

module system_asserts
    import system_pkg::*;
(
    input logic       i_clk,
    input logic       i_rst_n,
    input bus_state_t i_state,
    input logic       i_wb_cyc,
    input logic       i_wb_stb,
    input logic       i_wb_ack,
    input logic       i_wb_err,
    input slave_sel_t i_slv_stb
);

    // Response is due on the third edge after the sampled strobe
    property p_resp_latency;
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_state == BUS_IDLE && i_wb_cyc && i_wb_stb) |->
            ##1 !(i_wb_ack || i_wb_err) ##1 !(i_wb_ack || i_wb_err) ##1 (i_wb_ack || i_wb_err);
    endproperty

    a_ack_err_exclusive: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(i_wb_ack && i_wb_err)
    ) else $error("o_wb_ack and o_wb_err high in the same cycle");

    a_resp_latency: assert property (p_resp_latency)
        else $error("bus response not exactly 3 cycles after the strobe");

    a_slv_stb_onehot: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) $onehot0(i_slv_stb)
    ) else $error("more than one slave strobe active");

endmodule

bind wb_bus_ctrl system_asserts u_system_asserts (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_state   (state),
    .i_wb_cyc  (i_wb_cyc),
    .i_wb_stb  (i_wb_stb),
    .i_wb_ack  (o_wb_ack),
    .i_wb_err  (o_wb_err),
    .i_slv_stb (o_slv_stb)
);

//--- verilog/system.sv
// --------------------------------------------------------------------------
// System top level
// Wishbone master port into the bus controller, with the boot memory,
// timers and interrupt controller on the slave side
// --------------------------------------------------------------------------

`include "system_settings.svh"

module system
    import system_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  wb_addr_t i_wb_adr,
    input  wb_sel_t  i_wb_sel,
    input  logic     i_wb_we,
    input  logic     i_wb_cyc,
    input  logic     i_wb_stb,
    input  wb_data_t i_wb_dat,
    output wb_data_t o_wb_dat,
    output logic     o_wb_ack,
    output logic     o_wb_err,
    output logic     o_irq
);

    // Shared slave bus
    wb_addr_t   slv_adr;
    logic       slv_we;
    wb_sel_t    slv_sel;
    wb_data_t   slv_wdat;
    slave_sel_t slv_stb;

    // Slave responses
    logic       mem_ack;
    wb_data_t   mem_rdat;
    logic       tmr_ack;
    wb_data_t   tmr_rdat;
    logic       ic_ack;
    wb_data_t   ic_rdat;

    // Timer interrupt lines into the interrupt controller
    logic [`NUM_TIMERS-1:0] timer_int;

    wb_bus_ctrl u_wb_bus_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb_adr   (i_wb_adr),
        .i_wb_sel   (i_wb_sel),
        .i_wb_we    (i_wb_we),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_dat   (i_wb_dat),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .o_wb_err   (o_wb_err),
        .o_slv_adr  (slv_adr),
        .o_slv_we   (slv_we),
        .o_slv_sel  (slv_sel),
        .o_slv_wdat (slv_wdat),
        .o_slv_stb  (slv_stb),
        .i_mem_ack  (mem_ack),
        .i_mem_rdat (mem_rdat),
        .i_tmr_ack  (tmr_ack),
        .i_tmr_rdat (tmr_rdat),
        .i_ic_ack   (ic_ack),
        .i_ic_rdat  (ic_rdat)
    );

    boot_mem u_boot_mem (
        .i_clk  (i_clk),
        .i_stb  (slv_stb[SLV_MEM]),
        .i_we   (slv_we),
        .i_adr  (slv_adr),
        .i_sel  (slv_sel),
        .i_wdat (slv_wdat),
        .o_ack  (mem_ack),
        .o_rdat (mem_rdat)
    );

    timer_module u_timer_module (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_stb       (slv_stb[SLV_TMR]),
        .i_we        (slv_we),
        .i_adr       (slv_adr),
        .i_wdat      (slv_wdat),
        .o_ack       (tmr_ack),
        .o_rdat      (tmr_rdat),
        .o_timer_int (timer_int)
    );

    interrupt_controller u_interrupt_controller (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_stb       (slv_stb[SLV_IC]),
        .i_we        (slv_we),
        .i_adr       (slv_adr),
        .i_wdat      (slv_wdat),
        .i_timer_int (timer_int),
        .o_ack       (ic_ack),
        .o_rdat      (ic_rdat),
        .o_irq       (o_irq)
    );

endmodule

//--- verilog/interrupt_controller.sv
// --------------------------------------------------------------------------
// Interrupt controller
// Combines the timer flags and a software bit into raw status, masks it
// with an enable register and drives a registered interrupt request
// --------------------------------------------------------------------------

`include "system_settings.svh"

module interrupt_controller
    import system_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_stb,
    input  logic                   i_we,
    input  wb_addr_t               i_adr,
    input  wb_data_t               i_wdat,
    input  logic [`NUM_TIMERS-1:0] i_timer_int,
    output logic                   o_ack,
    output wb_data_t               o_rdat,
    output logic                   o_irq
);

    irq_vec_t raw;
    irq_vec_t status;
    irq_vec_t enable_q;
    irq_vec_t wr_bits;
    logic     soft_q;
    logic     wr;

    assign raw     = {soft_q, i_timer_int};
    assign status  = raw & enable_q;
    assign wr_bits = i_wdat[$bits(irq_vec_t)-1:0];
    assign wr      = i_stb && i_we;

    // ----------------------------------------------------------------------
    // Enable and software registers
    // ----------------------------------------------------------------------
    // Set/clear registers act on the 1 bits of the write data,
    // the software interrupt uses data bit 0
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            enable_q <= '0;
            soft_q   <= 1'b0;
            o_irq    <= 1'b0;
            o_ack    <= 1'b0;
        end else begin
            if (wr) begin
                case (i_adr[7:0])
                    `IC_ENABLE_SET:   enable_q <= enable_q | wr_bits;
                    `IC_ENABLE_CLEAR: enable_q <= enable_q & ~wr_bits;
                    `IC_SOFT_SET:     soft_q   <= soft_q | i_wdat[0];
                    `IC_SOFT_CLEAR:   soft_q   <= soft_q & ~i_wdat[0];
                    default: ;
                endcase
            end
            o_irq <= |status;
            o_ack <= i_stb;
        end
    end

    // ----------------------------------------------------------------------
    // Read data
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            case (i_adr[7:0])
                `IC_STATUS:       o_rdat <= wb_data_t'(status);
                `IC_RAW_STATUS:   o_rdat <= wb_data_t'(raw);
                `IC_ENABLE_SET,
                `IC_ENABLE_CLEAR: o_rdat <= wb_data_t'(enable_q);
                `IC_SOFT_SET,
                `IC_SOFT_CLEAR:   o_rdat <= wb_data_t'(soft_q);
                default:          o_rdat <= '0;
            endcase
        end
    end

endmodule

//--- verilog/timer_module.sv
// --------------------------------------------------------------------------
// Timer block
// Reloadable 16-bit down counters, each with a load value, an enable bit
// and a sticky interrupt flag that software clears
// --------------------------------------------------------------------------

`include "system_settings.svh"

module timer_module
    import system_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_stb,
    input  logic                   i_we,
    input  wb_addr_t               i_adr,
    input  wb_data_t               i_wdat,
    output logic                   o_ack,
    output wb_data_t               o_rdat,
    output logic [`NUM_TIMERS-1:0] o_timer_int
);

    timer_count_t           load_q  [`NUM_TIMERS];
    timer_count_t           count_q [`NUM_TIMERS];
    logic [`NUM_TIMERS-1:0] enable_q;
    logic [`NUM_TIMERS-1:0] flag_q;

    logic [1:0] tmr_idx;
    logic [7:0] reg_off;
    logic       tmr_hit;
    logic       wr;

    // Bits 9..8 pick the timer, the low byte picks the register
    assign tmr_idx = i_adr[9:8];
    assign reg_off = i_adr[7:0];
    assign tmr_hit = tmr_idx < `NUM_TIMERS;
    assign wr      = i_stb && i_we;

    // ----------------------------------------------------------------------
    // Counters and register writes
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int t = 0; t < `NUM_TIMERS; t++) begin
                load_q[t]  <= '0;
                count_q[t] <= '0;
            end
            enable_q <= '0;
            flag_q   <= '0;
        end else begin
            for (int t = 0; t < `NUM_TIMERS; t++) begin
                if (enable_q[t]) begin
                    // Expiry at one, reload and flag
                    if (count_q[t] == timer_count_t'(1)) begin
                        count_q[t] <= load_q[t];
                        flag_q[t]  <= 1'b1;
                    end else begin
                        count_q[t] <= count_q[t] - 1'b1;
                    end
                end

                // Bus write wins over the count in the same cycle
                if (wr && tmr_idx == t[1:0]) begin
                    case (reg_off)
                        `TIMER_LOAD: begin
                            load_q[t]  <= i_wdat[15:0];
                            count_q[t] <= i_wdat[15:0];
                        end
                        `TIMER_VALUE: count_q[t]  <= i_wdat[15:0];
                        `TIMER_CTRL:  enable_q[t] <= i_wdat[0];
                        `TIMER_CLEAR: flag_q[t]   <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Bus response
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_stb) begin
            o_rdat <= '0;
            if (tmr_hit) begin
                case (reg_off)
                    `TIMER_LOAD:  o_rdat <= wb_data_t'(load_q[tmr_idx]);
                    `TIMER_VALUE: o_rdat <= wb_data_t'(count_q[tmr_idx]);
                    `TIMER_CTRL:  o_rdat <= wb_data_t'(enable_q[tmr_idx]);
                    // Reading the clear register shows the pending flag
                    `TIMER_CLEAR: o_rdat <= wb_data_t'(flag_q[tmr_idx]);
                    default:      o_rdat <= '0;
                endcase
            end
        end
    end

    assign o_timer_int = flag_q;

endmodule

//--- verilog/boot_mem.sv
// --------------------------------------------------------------------------
// Boot memory
// Word-wide on-chip RAM with byte write enables on the system bus
// --------------------------------------------------------------------------

`include "system_settings.svh"

module boot_mem
    import system_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_stb,
    input  logic     i_we,
    input  wb_addr_t i_adr,
    input  wb_sel_t  i_sel,
    input  wb_data_t i_wdat,
    output logic     o_ack,
    output wb_data_t o_rdat
);

    localparam int ADDR_W = $clog2(`BOOT_MEM_WORDS);

    wb_data_t          mem [`BOOT_MEM_WORDS];
    logic [ADDR_W-1:0] word_idx;

    // Word index sits above the byte offset
    assign word_idx = i_adr[ADDR_W+1:2];

    always_ff @(posedge i_clk) begin
        if (i_stb && i_we) begin
            for (int b = 0; b < $bits(wb_sel_t); b++) begin
                if (i_sel[b]) begin
                    mem[word_idx][8*b +: 8] <= i_wdat[8*b +: 8];
                end
            end
        end
        // Read returns the word as it was before a same-cycle write
        if (i_stb) begin
            o_rdat <= mem[word_idx];
        end
    end

    // One-cycle ack for every strobe
    always_ff @(posedge i_clk) begin
        o_ack <= i_stb;
    end

endmodule

//--- verilog/wb_bus_ctrl.sv
// --------------------------------------------------------------------------
// Wishbone bus controller
// Accepts one access from the master, decodes the address region and
// strobes one slave. Returns ack with the slave's read data, or err with
// zero data when no slave claims the region.
// --------------------------------------------------------------------------

`include "system_settings.svh"

module wb_bus_ctrl
    import system_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,

    // Master side
    input  wb_addr_t   i_wb_adr,
    input  wb_sel_t    i_wb_sel,
    input  logic       i_wb_we,
    input  logic       i_wb_cyc,
    input  logic       i_wb_stb,
    input  wb_data_t   i_wb_dat,
    output wb_data_t   o_wb_dat,
    output logic       o_wb_ack,
    output logic       o_wb_err,

    // Shared slave side
    output wb_addr_t   o_slv_adr,
    output logic       o_slv_we,
    output wb_sel_t    o_slv_sel,
    output wb_data_t   o_slv_wdat,
    output slave_sel_t o_slv_stb,
    input  logic       i_mem_ack,
    input  wb_data_t   i_mem_rdat,
    input  logic       i_tmr_ack,
    input  wb_data_t   i_tmr_rdat,
    input  logic       i_ic_ack,
    input  wb_data_t   i_ic_rdat
);

    bus_state_t state;
    slave_sel_t region_sel;
    slave_sel_t target_q;
    slave_sel_t slv_ack;
    logic       issued_q;
    logic       start;
    logic       ack_seen;
    wb_data_t   rdat_mux;

    assign start = i_wb_cyc && i_wb_stb;

    // ----------------------------------------------------------------------
    // Region decode and response select
    // ----------------------------------------------------------------------
    always_comb begin
        region_sel = '0;
        case (i_wb_adr[31:24])
            `BUS_REGION_BOOT_MEM: region_sel[SLV_MEM] = 1'b1;
            `BUS_REGION_TIMER:    region_sel[SLV_TMR] = 1'b1;
            `BUS_REGION_IC:       region_sel[SLV_IC]  = 1'b1;
            default:              region_sel = '0;
        endcase
    end

    assign slv_ack[SLV_MEM] = i_mem_ack;
    assign slv_ack[SLV_TMR] = i_tmr_ack;
    assign slv_ack[SLV_IC]  = i_ic_ack;

    // Only the targeted slave's ack counts, an unmapped access sees none
    assign ack_seen = |(target_q & slv_ack);

    always_comb begin
        rdat_mux = '0;
        if (target_q[SLV_MEM]) begin
            rdat_mux = i_mem_rdat;
        end
        if (target_q[SLV_TMR]) begin
            rdat_mux = i_tmr_rdat;
        end
        if (target_q[SLV_IC]) begin
            rdat_mux = i_ic_rdat;
        end
    end

    // Strobe lasts the first ACCESS cycle only
    assign o_slv_stb = (state == BUS_ACCESS && issued_q) ? target_q : '0;

    // ----------------------------------------------------------------------
    // Access FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state    <= BUS_IDLE;
            target_q <= '0;
            issued_q <= 1'b0;
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (start) begin
                        target_q <= region_sel;
                        issued_q <= 1'b1;
                        state    <= BUS_ACCESS;
                    end
                end
                BUS_ACCESS: begin
                    if (issued_q) begin
                        issued_q <= 1'b0;
                    end else begin
                        // Slave ack is due now
                        o_wb_ack <= ack_seen;
                        o_wb_err <= !ack_seen;
                        state    <= BUS_RESPOND;
                    end
                end
                BUS_RESPOND: begin
                    o_wb_ack <= 1'b0;
                    o_wb_err <= 1'b0;
                    state    <= BUS_IDLE;
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    // Latched access and returned read data
    always_ff @(posedge i_clk) begin
        if (state == BUS_IDLE && start) begin
            o_slv_adr  <= i_wb_adr;
            o_slv_we   <= i_wb_we;
            o_slv_sel  <= i_wb_sel;
            o_slv_wdat <= i_wb_dat;
        end
        if (state == BUS_ACCESS && !issued_q) begin
            o_wb_dat <= ack_seen ? rdat_mux : '0;
        end
    end

endmodule

//--- verilog/system_pkg.sv
// --------------------------------------------------------------------------
// System package
// Bus, counter and interrupt types shared by the system bus blocks
// --------------------------------------------------------------------------

`include "system_settings.svh"

package system_pkg;

    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    typedef logic [15:0] timer_count_t;

    // Timers in the low bits, software interrupt on top
    typedef logic [`NUM_TIMERS:0] irq_vec_t;

    // One-hot slave strobes
    typedef logic [2:0] slave_sel_t;

    // Bit positions within slave_sel_t
    localparam int SLV_MEM = 0;
    localparam int SLV_TMR = 1;
    localparam int SLV_IC  = 2;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_ACCESS,
        BUS_RESPOND
    } bus_state_t;

endpackage

//--- verilog/system_settings.svh
// --------------------------------------------------------------------------
// System settings
// Address map, slave register offsets and memory sizes for the system bus
// --------------------------------------------------------------------------

`ifndef SYSTEM_SETTINGS_SVH
`define SYSTEM_SETTINGS_SVH

// Region decode on address bits 31..24
`define BUS_REGION_BOOT_MEM 8'h00
`define BUS_REGION_TIMER    8'h13
`define BUS_REGION_IC       8'h14

// Boot memory depth in 32-bit words
`define BOOT_MEM_WORDS 256

`define NUM_TIMERS 3

// Timer registers, one block per timer at a 0x100 stride
`define TIMER_LOAD  8'h00
`define TIMER_VALUE 8'h04
`define TIMER_CTRL  8'h08
`define TIMER_CLEAR 8'h0C

// Interrupt controller registers
`define IC_STATUS       8'h00
`define IC_RAW_STATUS   8'h04
`define IC_ENABLE_SET   8'h08
`define IC_ENABLE_CLEAR 8'h0C
`define IC_SOFT_SET     8'h10
`define IC_SOFT_CLEAR   8'h14

`endif
